//--- compile.f
+incdir+design
design/arrayHeapPkg.sv
design/heapIfs.sv
design/arrayAllocator.sv
design/elementAlu.sv
design/arraySearch.sv
design/heapController.sv
design/arrayHeap.sv
verification/arrayHeap_chk.sv
verification/arrayHeapTb.sv

//--- Makefile
TOP = arrayHeapTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null

clean:
	rm -rf obj_dir

//--- verification/arrayHeap_golden.txt
// Columns in hex: opcode array index data, then expected data and expected error
// Ops 00 clr 01 alloc 02 free 03 wr 04 rd 05 size 06 push 07 pop 08 idx 09 lt 0a gt 0b+ alu
00 0 0 000 000 0
01 0 0 000 000 0
01 0 0 000 001 0
01 0 0 000 002 0
02 1 0 000 000 0
02 0 0 000 000 0
01 0 0 000 000 0
01 0 0 000 001 0
02 2 0 000 000 0
02 2 0 000 000 1
01 0 0 000 002 0
01 0 0 000 003 0
01 0 0 000 004 0
01 0 0 000 005 0
01 0 0 000 006 0
01 0 0 000 007 0
01 0 0 000 000 5
03 0 5 123 123 0
05 0 0 000 006 0
04 0 5 000 123 0
04 0 6 000 000 2
02 7 0 000 000 0
04 7 0 000 000 1
03 7 1 055 000 1
07 1 0 000 000 4
06 1 0 00a 00a 0
06 1 0 00b 00b 0
06 1 0 00c 00c 0
07 1 0 000 00c 0
07 1 0 000 00b 0
05 1 0 000 001 0
06 0 0 007 007 0
06 0 0 008 008 0
06 0 0 009 000 3
04 0 7 000 008 0
08 2 0 000 000 0
06 2 0 005 005 0
06 2 0 003 003 0
06 2 0 005 005 0
06 2 0 009 009 0
08 2 0 005 003 0
08 2 0 007 000 0
09 2 0 005 001 0
0a 2 0 004 003 0
0a 2 0 009 000 0
09 3 0 001 000 0
08 7 0 000 000 1
0b 1 0 ff8 002 0
0c 1 0 003 002 0
04 1 0 000 005 0
0d 1 0 007 ffe 0
0e 1 0 001 ffe 0
04 1 0 000 ffd 0
0f 1 0 004 fd0 0
10 1 0 003 1fa 0
0f 1 0 00c 000 0
11 1 0 000 001 0
11 1 0 000 000 0
12 1 0 000 fff 0
15 1 0 0f0 0f0 0
13 1 0 303 3f3 0
14 1 0 0ff 30c 0
04 1 0 000 30c 0
0b 1 1 001 000 2
00 0 0 000 000 0
05 1 0 000 000 1
01 0 0 000 000 0

//--- verification/arrayHeapTb.sv
//----------------------------------------
// Testbench for the array heap that replays the
// golden request file and checks every response
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arrayHeapTb import arrayHeapPkg::*; ();

  localparam int ClockPeriod = 20;
  localparam int DriveDelay  = 2;                      // After the rising edge
  localparam int MaxVectors  = 128;
  localparam int CyclesPerReq = 20;                    // Watchdog budget per request

  logic      clock;
  logic      reset;
  logic      reqValid;
  logic      reqReady;
  heapOpT    reqOp;
  arrayIdT   reqArray;
  elemIndexT reqIndex;
  elemT      reqData;
  logic      rspValid;
  logic      rspReady;
  elemT      rspData;
  heapErrT   rspError;

  logic [15:0] vecOp      [MaxVectors];                // Golden file columns
  logic [15:0] vecArray   [MaxVectors];
  logic [15:0] vecIndex   [MaxVectors];
  logic [15:0] vecData    [MaxVectors];
  logic [15:0] vecExpData [MaxVectors];
  logic [15:0] vecExpErr  [MaxVectors];

  int   vectorCount;
  int   errorCount;
  int   checkCount;
  int   currentVector;
  int   seed;                                          // For rspReady stalls
  logic loadDone;

  arrayHeap dut0 (
    .clock    (clock),
    .reset    (reset),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .reqOp    (reqOp),
    .reqArray (reqArray),
    .reqIndex (reqIndex),
    .reqData  (reqData),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rspData  (rspData),
    .rspError (rspError)
  );

  initial begin
    clock = 1'b0;
    forever #(ClockPeriod / 2) clock = ~clock;
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------
  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAIL %0t ns: request %0d %s expected %0h, got %0h",
               $time, currentVector, name, expected, actual);
    end
  endtask

  task automatic loadGolden();
    int          fd;
    int          fields;
    logic        done;
    logic [8*120-1:0] headerLine;
    logic [15:0] op;
    logic [15:0] arr;
    logic [15:0] idx;
    logic [15:0] data;
    logic [15:0] expData;
    logic [15:0] expErr;
    fd = $fopen("verification/arrayHeap_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file verification/arrayHeap_golden.txt");
      errorCount++;
    end else begin
      void'($fgets(headerLine, fd));                   // Column description
      void'($fgets(headerLine, fd));                   // Opcode list
      done = 1'b0;
      while (!done) begin
        fields = $fscanf(fd, "%h %h %h %h %h %h\n", op, arr, idx, data, expData, expErr);
        if (fields == 6 && vectorCount < MaxVectors) begin
          vecOp[vectorCount]      = op;
          vecArray[vectorCount]   = arr;
          vecIndex[vectorCount]   = idx;
          vecData[vectorCount]    = data;
          vecExpData[vectorCount] = expData;
          vecExpErr[vectorCount]  = expErr;
          vectorCount++;
        end else begin
          if (!$feof(fd)) begin
            $display("The golden file cannot be read after request %0d", vectorCount);
            errorCount++;
          end
          done = 1'b1;
        end
      end
      $fclose(fd);
      if (vectorCount == 0) begin
        $display("The golden file holds no requests");
        errorCount++;
      end
    end
  endtask

  // Starts and ends a drive delay after a rising edge
  task automatic runRequest(input int i);
    int holdCycles;
    reqOp    = heapOpT'(vecOp[i][4:0]);
    reqArray = arrayIdT'(vecArray[i]);
    reqIndex = elemIndexT'(vecIndex[i]);
    reqData  = elemT'(vecData[i]);
    reqValid = 1'b1;
    @(negedge clock);
    while (!reqReady) @(negedge clock);                // Stable until next edge
    @(posedge clock);                                  // Accepted here
    #DriveDelay reqValid = 1'b0;
    @(negedge clock);
    while (!rspValid) @(negedge clock);
    holdCycles = $unsigned($random(seed)) % 4;         // Back-pressure 0 to 3
    repeat (holdCycles) @(negedge clock);
    @(posedge clock);
    #DriveDelay rspReady = 1'b1;
    @(negedge clock);
    checkValue("rspData", vecExpData[i], 16'(rspData));
    checkValue("rspError", vecExpErr[i], 16'(rspError));
    @(posedge clock);                                  // Response taken
    #DriveDelay rspReady = 1'b0;
  endtask

  //----------------------------------------
  // Main flow
  //----------------------------------------
  initial begin : mainFlow
    int i;
    int assertFails;
    reset         = 1'b0;
    reqValid      = 1'b0;
    reqOp         = opClear;
    reqArray      = '0;
    reqIndex      = '0;
    reqData       = '0;
    rspReady      = 1'b0;
    errorCount    = 0;
    checkCount    = 0;
    vectorCount   = 0;
    currentVector = 0;
    seed          = 6;
    loadDone      = 1'b0;
    loadGolden();
    loadDone = 1'b1;                                   // Starts the watchdog
    repeat (4) @(posedge clock);
    #DriveDelay reset = 1'b1;
    for (i = 0; i < vectorCount; i++) begin
      currentVector = i;
      runRequest(i);
    end
    assertFails = dut0.chk0.failCount;                 // Bound handshake checker
    $display("Requests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             vectorCount, checkCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Ends a hung run
  initial begin : watchdog
    longint limit;
    wait (loadDone);
    limit = (longint'(vectorCount) * CyclesPerReq + 8) * ClockPeriod;
    #(limit);
    $display("Timeout: the requests did not finish within %0d ns", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/arrayHeap_chk.sv
//----------------------------------------
// Handshake assertions for the heap top
// Attached to it by the bind at the end of the file
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arrayHeapChk import arrayHeapPkg::*; (
  input logic    clock,
  input logic    reset,
  input logic    reqReady,
  input logic    rspValid,
  input logic    rspReady,
  input elemT    rspData,
  input heapErrT rspError
);

  int unsigned failCount = 0;                          // Failed assertions so far

  // Stalled response keeps its contents
  responseHeld: assert property (@(posedge clock) disable iff (!reset)
    rspValid && !rspReady |=> rspValid && $stable(rspData) && $stable(rspError))
    else begin
      failCount++;
      $error("Response changed while rspReady was low");
    end

  // Never ready for a request with a response pending
  oneInFlight: assert property (@(posedge clock) disable iff (!reset)
    !(reqReady && rspValid))
    else begin
      failCount++;
      $error("reqReady and rspValid were high together");
    end

  // A taken response is gone in the next cycle
  responseTaken: assert property (@(posedge clock) disable iff (!reset)
    rspValid && rspReady |=> !rspValid)
    else begin
      failCount++;
      $error("rspValid stayed high after the response was taken");
    end

endmodule

bind arrayHeap arrayHeapChk chk0 (
  .clock    (clock),
  .reset    (reset),
  .reqReady (reqReady),
  .rspValid (rspValid),
  .rspReady (rspReady),
  .rspData  (rspData),
  .rspError (rspError)
);

`default_nettype wire

//--- design/arrayHeap.sv
//----------------------------------------
// Array heap top: 8 arrays of 8 elements behind
// a valid/ready request and response channel
//----------------------------------------
`timescale 1ns/1ns
`include "arrayHeap_macros.svh"
`default_nettype none

module arrayHeap import arrayHeapPkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      reqValid,
  output logic      reqReady,
  input  heapOpT    reqOp,
  input  arrayIdT   reqArray,
  input  elemIndexT reqIndex,
  input  elemT      reqData,
  output logic      rspValid,
  input  logic      rspReady,
  output elemT      rspData,
  output heapErrT   rspError
);

  allocIf  allocBus ();                                // Controller to allocator
  searchIf searchBus ();                               // Controller to search unit

  heapOpT aluOp;
  elemT   aluOld;
  elemT   aluOperand;
  elemT   aluNew;
  elemT   aluResult;

  heapController ctrl0 (
    .clock      (clock),
    .reset      (reset),
    .reqValid   (reqValid),
    .reqReady   (reqReady),
    .reqOp      (reqOp),
    .reqArray   (reqArray),
    .reqIndex   (reqIndex),
    .reqData    (reqData),
    .rspValid   (rspValid),
    .rspReady   (rspReady),
    .rspData    (rspData),
    .rspError   (rspError),
    .alloc      (allocBus),
    .search     (searchBus),
    .aluOp      (aluOp),
    .aluOld     (aluOld),
    .aluOperand (aluOperand),
    .aluNew     (aluNew),
    .aluResult  (aluResult)
  );

  arrayAllocator alloc0 (.clock(clock), .reset(reset), .alloc(allocBus));

  arraySearch search0 (.clock(clock), .reset(reset), .search(searchBus));

  elementAlu alu0 (
    .aluOp      (aluOp),
    .aluOld     (aluOld),
    .aluOperand (aluOperand),
    .aluNew     (aluNew),
    .aluResult  (aluResult)
  );

endmodule

`default_nettype wire

//--- design/heapController.sv
//----------------------------------------
// Heap controller: request and response handshake,
// element memory, array sizes and access checks
//----------------------------------------
`timescale 1ns/1ns
`include "arrayHeap_macros.svh"
`default_nettype none

module heapController import arrayHeapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         reqValid,
  output logic         reqReady,
  input  heapOpT       reqOp,
  input  arrayIdT      reqArray,
  input  elemIndexT    reqIndex,
  input  elemT         reqData,
  output logic         rspValid,
  input  logic         rspReady,
  output elemT         rspData,
  output heapErrT      rspError,
  allocIf.controller   alloc,
  searchIf.controller  search,
  output heapOpT       aluOp,
  output elemT         aluOld,
  output elemT         aluOperand,
  input  elemT         aluNew,
  input  elemT         aluResult
);

  typedef enum logic [1:0] {idle, waitAlloc, waitSearch, respond} ctrlStateT;

  ctrlStateT state;
  elemT      mem [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];   // Element storage
  arraySizeT sizes [`HEAP_ARRAYS];                     // Size of each array
  heapOpT    opReg;                                    // Request kept for long ops
  arrayIdT   arrayReg;
  elemT      dataReg;

  logic      accept;
  logic      readable;
  logic      memWrite;
  logic      sizeWrite;
  heapErrT   checkErr;
  arraySizeT curSize;
  arraySizeT lastPos;
  arraySizeT nextSize;
  elemIndexT wrIndex;
  elemT      wrValue;
  elemT      curElem;
  elemT      opResult;

  assign reqReady = (state == idle);                   // One request in flight
  assign rspValid = (state == respond);
  assign accept   = reqValid && reqReady;
  assign curSize  = sizes[reqArray];
  assign lastPos  = curSize - 1'b1;
  assign curElem  = mem[reqArray][reqIndex];
  assign readable = alloc.isAllocated && ({1'b0, reqIndex} < curSize);

  assign aluOp      = reqOp;
  assign aluOld     = curElem;
  assign aluOperand = reqData;

  assign alloc.allocOp    = opReg;
  assign alloc.allocArray = (state == idle) ? reqArray : arrayReg;  // Check, then free

  assign search.searchMode = (opReg == opIndex) ? findIndex :
                             (opReg == opLess)  ? countLess : countGreater;
  assign search.searchKey  = dataReg;
  assign search.searchSize = sizes[arrayReg];
  assign search.readData   = mem[arrayReg][search.readIndex];

  //----------------------------------------
  // Checks and single cycle operations
  //----------------------------------------
  always_comb begin
    checkErr  = errNone;
    memWrite  = 1'b0;
    sizeWrite = 1'b0;
    wrIndex   = reqIndex;
    wrValue   = reqData;
    nextSize  = curSize;
    opResult  = curElem;
    if (!alloc.isAllocated && reqOp != opClear && reqOp != opAlloc) begin
      checkErr = errNotAllocated;
    end else begin
      case (reqOp)
        opWrite: begin
          memWrite  = 1'b1;
          sizeWrite = 1'b1;
          nextSize  = ({1'b0, reqIndex} >= curSize) ? {1'b0, reqIndex} + 1'b1 : curSize;
          opResult  = reqData;
        end
        opRead: if (!readable) checkErr = errOutOfBounds;
        opSize: opResult = elemT'(curSize);
        opPush: begin
          if (curSize == `HEAP_ARRAY_LENGTH) begin
            checkErr = errFull;
          end else begin
            memWrite  = 1'b1;
            sizeWrite = 1'b1;
            wrIndex   = curSize[`HEAP_INDEX_BITS-1:0];  // Append at the end
            nextSize  = curSize + 1'b1;
            opResult  = reqData;
          end
        end
        opPop: begin
          if (curSize == '0) begin
            checkErr = errEmpty;
          end else begin
            sizeWrite = 1'b1;
            nextSize  = lastPos;
            opResult  = mem[reqArray][lastPos[`HEAP_INDEX_BITS-1:0]];
          end
        end
        default: begin
          if (reqOp inside {[opAdd:opAnd]}) begin     // Element operations
            if (!readable) begin
              checkErr = errOutOfBounds;
            end else begin
              memWrite = 1'b1;
              wrValue  = aluNew;
              opResult = aluResult;
            end
          end
        end
      endcase
    end
  end

  //----------------------------------------
  // Memory, sizes and request copy
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (accept && memWrite) mem[reqArray][wrIndex] <= wrValue;
    if (accept && sizeWrite) begin
      sizes[reqArray] <= nextSize;
    end else if (state == waitAlloc && alloc.allocDone && opReg == opAlloc
                 && alloc.allocErr == errNone) begin
      sizes[alloc.allocId] <= '0;                      // Fresh array is empty
    end
    if (accept) begin
      opReg    <= reqOp;
      arrayReg <= reqArray;
      dataReg  <= reqData;
    end
  end

  //----------------------------------------
  // FSM and response register
  //----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state              <= idle;
      alloc.allocStart   <= 1'b0;
      search.searchStart <= 1'b0;
      rspData            <= '0;
      rspError           <= errNone;
    end else begin
      alloc.allocStart   <= 1'b0;                      // Starts are pulses
      search.searchStart <= 1'b0;
      case (state)
        idle: begin
          if (accept) begin
            if (checkErr != errNone) begin
              rspData  <= '0;                          // Failed, nothing changed
              rspError <= checkErr;
              state    <= respond;
            end else if (reqOp inside {opClear, opAlloc, opFree}) begin
              alloc.allocStart <= 1'b1;
              state            <= waitAlloc;
            end else if (reqOp inside {opIndex, opLess, opGreater}) begin
              search.searchStart <= 1'b1;
              state              <= waitSearch;
            end else begin
              rspData  <= opResult;
              rspError <= errNone;
              state    <= respond;
            end
          end
        end
        waitAlloc: begin
          if (alloc.allocDone) begin
            rspData  <= (opReg == opAlloc) ? elemT'(alloc.allocId) : '0;
            rspError <= alloc.allocErr;
            state    <= respond;
          end
        end
        waitSearch: begin
          if (search.searchDone) begin
            rspData  <= search.searchResult;
            rspError <= errNone;
            state    <= respond;
          end
        end
        respond: if (rspReady) state <= idle;          // Hold until taken
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/arraySearch.sv
//----------------------------------------
// Search unit: scans one array an element per
// cycle for last match, count less or count greater
//----------------------------------------
`timescale 1ns/1ns
`include "arrayHeap_macros.svh"
`default_nettype none

module arraySearch import arrayHeapPkg::*; (
  input  logic    clock,
  input  logic    reset,
  searchIf.search search
);

  logic      running;                                  // Scan in progress
  elemIndexT scanIndex;                                // Element being looked at
  arraySizeT acc;                                      // Last match or count so far
  arraySizeT nextAcc;
  logic      hit;
  logic      lastElem;

  assign search.readIndex = scanIndex;
  assign lastElem = ({1'b0, scanIndex} == search.searchSize - 1'b1);

  always_comb begin
    case (search.searchMode)
      countLess:    hit = search.readData < search.searchKey;
      countGreater: hit = search.readData > search.searchKey;
      default:      hit = search.readData == search.searchKey;
    endcase
    if (search.searchMode == findIndex) begin
      nextAcc = hit ? {1'b0, scanIndex} + 1'b1 : acc;  // Position plus 1
    end else begin
      nextAcc = acc + arraySizeT'(hit);
    end
  end

  // Done in the last scan cycle, or at start for an empty array
  assign search.searchDone   = running ? lastElem
                                       : (search.searchStart && search.searchSize == '0);
  assign search.searchResult = running ? elemT'(nextAcc) : '0;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      running   <= 1'b0;
      scanIndex <= '0;
      acc       <= '0;
    end else if (search.searchStart && search.searchSize != '0) begin
      running   <= 1'b1;                               // First element next cycle
      scanIndex <= '0;
      acc       <= '0;
    end else if (running) begin
      acc <= nextAcc;
      if (lastElem) begin
        running   <= 1'b0;
        scanIndex <= '0;
      end else begin
        scanIndex <= scanIndex + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/elementAlu.sv
//----------------------------------------
// Element operations: the stored value and
// the value returned to the client
//----------------------------------------
`timescale 1ns/1ns
`include "arrayHeap_macros.svh"
`default_nettype none

module elementAlu import arrayHeapPkg::*; (
  input  heapOpT aluOp,
  input  elemT   aluOld,                               // Element before the operation
  input  elemT   aluOperand,                           // Request data
  output elemT   aluNew,                               // Value to store
  output elemT   aluResult                             // Value to return
);

  always_comb begin
    case (aluOp)
      opAdd,
      opAddAfter:   aluNew = aluOld + aluOperand;      // Wraps at 12 bits
      opSub,
      opSubAfter:   aluNew = aluOld - aluOperand;
      opShiftLeft:  aluNew = aluOld << aluOperand;     // Data is the amount
      opShiftRight: aluNew = aluOld >> aluOperand;
      opNotLogical: aluNew = elemT'(aluOld == '0);     // 1 only for zero
      opNot:        aluNew = ~aluOld;
      opOr:         aluNew = aluOld | aluOperand;
      opXor:        aluNew = aluOld ^ aluOperand;
      opAnd:        aluNew = aluOld & aluOperand;
      default:      aluNew = aluOld;                   // Not an element op
    endcase
  end

  // After forms hand back the old content
  assign aluResult = (aluOp == opAddAfter || aluOp == opSubAfter) ? aluOld : aluNew;

endmodule

`default_nettype wire

//--- design/arrayAllocator.sv
//----------------------------------------
// Array allocator: a flag per array, a LIFO of
// freed numbers and a counter of fresh numbers
//----------------------------------------
`timescale 1ns/1ns
`include "arrayHeap_macros.svh"
`default_nettype none

module arrayAllocator import arrayHeapPkg::*; (
  input  logic      clock,
  input  logic      reset,
  allocIf.allocator alloc
);

  logic [`HEAP_ARRAYS-1:0] allocated;                  // One flag per array
  arrayIdT   freeStack [`HEAP_ARRAYS];                 // Freed numbers, newest on top
  arraySizeT stackTop;                                 // Entries on the stack
  arraySizeT topBelow;                                 // Slot of the newest entry
  arraySizeT freshCount;                               // Numbers never handed out

  assign topBelow          = stackTop - 1'b1;
  assign alloc.isAllocated = allocated[alloc.allocArray];   // Lookup for the checks

  //----------------------------------------
  // Stack storage
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (alloc.allocStart && alloc.allocOp == opFree && allocated[alloc.allocArray]) begin
      freeStack[stackTop[`HEAP_ADDRESS_BITS-1:0]] <= alloc.allocArray;  // Never full here
    end
  end

  //----------------------------------------
  // Clear, alloc and free
  //----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated       <= '0;
      stackTop        <= '0;
      freshCount      <= '0;
      alloc.allocDone <= 1'b0;
      alloc.allocId   <= '0;
      alloc.allocErr  <= errNone;
    end else begin
      alloc.allocDone <= alloc.allocStart;             // Answer one cycle later
      if (alloc.allocStart) begin
        alloc.allocId  <= '0;
        alloc.allocErr <= errNone;
        case (alloc.allocOp)
          opClear: begin
            allocated  <= '0;                          // Everything free
            stackTop   <= '0;                          // Stack emptied
            freshCount <= '0;                          // Restart at array 0
          end
          opAlloc: begin
            if (stackTop != '0) begin                  // Reuse the newest freed
              alloc.allocId <= freeStack[topBelow[`HEAP_ADDRESS_BITS-1:0]];
              allocated[freeStack[topBelow[`HEAP_ADDRESS_BITS-1:0]]] <= 1'b1;
              stackTop <= topBelow;
            end else if (freshCount < `HEAP_ARRAYS) begin
              alloc.allocId <= freshCount[`HEAP_ADDRESS_BITS-1:0];
              allocated[freshCount[`HEAP_ADDRESS_BITS-1:0]] <= 1'b1;
              freshCount <= freshCount + 1'b1;
            end else begin
              alloc.allocErr <= errOutOfMemory;        // All 8 in use
            end
          end
          opFree: begin
            if (!allocated[alloc.allocArray]) begin
              alloc.allocErr <= errNotAllocated;       // Double free
            end else begin
              allocated[alloc.allocArray] <= 1'b0;
              stackTop <= stackTop + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/heapIfs.sv
//----------------------------------------
// Internal buses of the heap: controller to
// allocator and controller to search unit
//----------------------------------------
`timescale 1ns/1ns
`include "arrayHeap_macros.svh"
`default_nettype none

interface allocIf import arrayHeapPkg::*; ();
  logic    allocStart;                                 // One cycle request
  heapOpT  allocOp;                                    // Clear, alloc or free
  arrayIdT allocArray;                                 // Array to free or look up
  logic    allocDone;                                  // Pulse a cycle after start
  arrayIdT allocId;                                    // Number handed out
  heapErrT allocErr;
  logic    isAllocated;                                // Flag of allocArray

  modport controller (output allocStart, allocOp, allocArray,
                      input  allocDone, allocId, allocErr, isAllocated);
  modport allocator  (input  allocStart, allocOp, allocArray,
                      output allocDone, allocId, allocErr, isAllocated);
endinterface

interface searchIf import arrayHeapPkg::*; ();
  logic       searchStart;                             // One cycle request
  searchModeT searchMode;
  elemT       searchKey;
  arraySizeT  searchSize;                              // Elements to scan
  elemT       readData;                                // Element at readIndex
  elemIndexT  readIndex;
  logic       searchDone;
  elemT       searchResult;

  modport controller (output searchStart, searchMode, searchKey, searchSize, readData,
                      input  readIndex, searchDone, searchResult);
  modport search     (input  searchStart, searchMode, searchKey, searchSize, readData,
                      output readIndex, searchDone, searchResult);
endinterface

`default_nettype wire

//--- design/arrayHeapPkg.sv
//----------------------------------------
// Shared types of the array heap: opcodes,
// error kinds, search modes and element widths
//----------------------------------------
`include "arrayHeap_macros.svh"
`default_nettype none

package arrayHeapPkg;

  typedef enum logic [4:0] {
    opClear,                                           // Free every array
    opAlloc,                                           // Hand out an array
    opFree,                                            // Return an array
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opIndex,                                           // Last match plus 1
    opLess,                                            // Count below key
    opGreater,                                         // Count above key
    opAdd,                                             // First element operation
    opAddAfter,
    opSub,
    opSubAfter,
    opShiftLeft,
    opShiftRight,
    opNotLogical,
    opNot,
    opOr,
    opXor,
    opAnd                                              // Last element operation
  } heapOpT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapErrT;

  typedef enum logic [1:0] {findIndex, countLess, countGreater} searchModeT;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayIdT;     // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   elemIndexT;   // Position in an array
  typedef logic [`HEAP_INDEX_BITS:0]     arraySizeT;   // Size 0 to 8
  typedef logic [`HEAP_DATA_BITS-1:0]    elemT;        // One element

endpackage

`default_nettype wire

//--- design/arrayHeap_macros.svh
//----------------------------------------
// Size settings for the array heap, included by
// the package and by every module that needs a width
//----------------------------------------
`ifndef ARRAY_HEAP_MACROS_SVH
`define ARRAY_HEAP_MACROS_SVH

`default_nettype none

`define HEAP_ADDRESS_BITS 3                            // Bits in an array number
`define HEAP_INDEX_BITS   3                            // Bits in an element index
`define HEAP_DATA_BITS    12                           // Bits in one element

`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)    // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)      // Elements per array

`default_nettype wire

`endif
